//--- logic/tag_pkg.sv
package tag_pkg;

  localparam int n_ways = 8;
  localparam int way_bits = 3;
  localparam int set_bits = 7;
  localparam int n_sets = 128;
  localparam int paddr_bits = 37; // Line address with the set index in the low bits
  localparam int tree_bits = 7;
  localparam int tag_bits = paddr_bits + 2;

  // Parity is the XOR of valid and paddr, so a good word always XORs to zero
  typedef struct packed {
    logic valid;
    logic [paddr_bits-1:0] paddr;
    logic parity;
  } tag_word_t;

  typedef enum logic [1:0] {
    OP_NONE,
    OP_FILL,  // Install a line, evicting if the set is full
    OP_INVAL, // Clear a matching line
    OP_INIT   // Clear the whole set and its tree
  } tag_op_e;

endpackage

//--- logic/tag_way_if.sv
`timescale 1ns/1ps

// Lookup results of one way that hold from the falling edge registering the request
interface tag_way_if import tag_pkg::*; ();

  logic rd_hit;
  logic rd_err;
  logic wr_match;
  logic wr_valid;
  logic [paddr_bits-1:0] wr_tag;

  modport way (
    output rd_hit,
    output rd_err,
    output wr_match,
    output wr_valid,
    output wr_tag
  );

  modport array (
    input rd_hit,
    input rd_err,
    input wr_match,
    input wr_valid,
    input wr_tag
  );

endinterface

//--- logic/tag_ram.sv
`timescale 1ns/1ps

module tag_ram import tag_pkg::*; #(
  parameter int width = tag_bits
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                rd_en,
  input  logic [set_bits-1:0] rd_addr,
  output logic [width-1:0]    rd_data,
  input  logic                wr_en,
  input  logic [set_bits-1:0] wr_addr,
  input  logic [width-1:0]    wr_data
);

  logic [width-1:0] mem [n_sets];
  logic [set_bits-1:0] rd_addr_q;

  // A write on the same edge shows up on rd_data right after it
  assign rd_data = mem[rd_addr_q];

  always_ff @(negedge clk) begin
    if (rst) begin
      rd_addr_q <= '0;
    end else if (rd_en) begin
      rd_addr_q <= rd_addr; // Held while the port is idle
    end
  end

  always_ff @(negedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

endmodule

//--- logic/plru_tree.sv
`timescale 1ns/1ps

// Node 0 is the root, nodes 1 and 2 the middle level, nodes 3 to 6 the leaves.
// A node bit of 1 means the victim lies in the upper half below that node
module plru_tree import tag_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 rd_en,
  input  logic [set_bits-1:0]  rd_set,
  input  logic                 hit,
  input  logic [way_bits-1:0]  hit_way,
  input  logic [set_bits-1:0]  wr_set,
  input  logic                 fill,
  input  logic [way_bits-1:0]  fill_way,
  input  logic                 init,
  output logic [tree_bits-1:0] wr_tree
);

  logic [set_bits-1:0] rd_set_q;
  logic [set_bits-1:0] wr_set_q;
  logic [set_bits-1:0] tree_addr;
  logic [tree_bits-1:0] rd_tree;
  logic [tree_bits-1:0] tree_new;
  logic tree_we;

  // Every node on the path to the used way is turned to point away from it
  function automatic logic [tree_bits-1:0] touch(input logic [tree_bits-1:0] t,
                                                  input logic [way_bits-1:0] w);
    logic [tree_bits-1:0] n;
    n = t;
    n[0] = ~w[2];
    n[1 + w[2]] = ~w[1];
    n[3 + {w[2], w[1]}] = ~w[0];
    return n;
  endfunction

  always_ff @(negedge clk) begin
    if (rd_en) begin
      rd_set_q <= rd_set;
    end
    wr_set_q <= wr_set;
  end

  // With a single write port a hit update loses to a fill or an init
  always_comb begin
    tree_we = 1'b1;
    tree_addr = wr_set_q;
    tree_new = '0;
    if (init) begin
      tree_new = '0;
    end else if (fill) begin
      tree_new = touch(wr_tree, fill_way);
    end else if (hit) begin
      tree_addr = rd_set_q;
      tree_new = touch(rd_tree, hit_way);
    end else begin
      tree_we = 1'b0;
    end
  end

  tag_ram #(.width(tree_bits)) u_rd_tree (
    .clk     (clk),
    .rst     (rst),
    .rd_en   (rd_en),
    .rd_addr (rd_set),
    .rd_data (rd_tree),
    .wr_en   (tree_we),
    .wr_addr (tree_addr),
    .wr_data (tree_new)
  );

  tag_ram #(.width(tree_bits)) u_wr_tree (
    .clk     (clk),
    .rst     (rst),
    .rd_en   (1'b1),
    .rd_addr (wr_set),
    .rd_data (wr_tree),
    .wr_en   (tree_we),
    .wr_addr (tree_addr),
    .wr_data (tree_new)
  );

endmodule

//--- logic/tag_way.sv
`timescale 1ns/1ps

module tag_way import tag_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  read_en,
  input  logic [paddr_bits-1:0] read_paddr,
  input  logic [paddr_bits-1:0] write_paddr,
  input  logic [paddr_bits-1:0] write_paddr_q,
  input  logic                  wr_en,
  input  tag_word_t             wr_word,
  tag_way_if.way                res
);

  logic [paddr_bits-1:0] read_paddr_q;
  logic read_en_q;
  tag_word_t rd_word;
  tag_word_t wp_word;

  always_ff @(negedge clk) begin
    if (rst) begin
      read_en_q <= 1'b0;
    end else begin
      read_en_q <= read_en;
    end
  end

  always_ff @(negedge clk) begin
    if (read_en) begin
      read_paddr_q <= read_paddr;
    end
  end

  // Both copies take the same writes and each stream looks up its own copy
  tag_ram #(.width(tag_bits)) u_rd_ram (
    .clk     (clk),
    .rst     (rst),
    .rd_en   (read_en),
    .rd_addr (read_paddr[set_bits-1:0]),
    .rd_data (rd_word),
    .wr_en   (wr_en),
    .wr_addr (write_paddr_q[set_bits-1:0]),
    .wr_data (wr_word)
  );

  tag_ram #(.width(tag_bits)) u_wr_ram (
    .clk     (clk),
    .rst     (rst),
    .rd_en   (1'b1),
    .rd_addr (write_paddr[set_bits-1:0]),
    .rd_data (wp_word),
    .wr_en   (wr_en),
    .wr_addr (write_paddr_q[set_bits-1:0]),
    .wr_data (wr_word)
  );

  assign res.rd_hit = read_en_q & rd_word.valid & (rd_word.paddr == read_paddr_q);
  assign res.rd_err = read_en_q & (^rd_word); // Cleared words pass the check too

  assign res.wr_match = wp_word.valid & (wp_word.paddr == write_paddr_q);
  assign res.wr_valid = wp_word.valid;
  assign res.wr_tag = wp_word.paddr;

endmodule

//--- logic/tag_array.sv
`timescale 1ns/1ps

module tag_array import tag_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  read_en,
  input  logic [paddr_bits-1:0] read_paddr,
  output logic                  read_hit,
  output logic [way_bits-1:0]   read_way,
  output logic                  read_err,
  input  tag_op_e               write_op,
  input  logic [paddr_bits-1:0] write_paddr,
  output logic                  expun_en,
  output logic [paddr_bits-1:0] expun_addr
);

  tag_op_e op_q;
  logic [paddr_bits-1:0] write_paddr_q;
  logic [n_ways-1:0] hit_vec;
  logic [n_ways-1:0] err_vec;
  logic [n_ways-1:0] match_vec;
  logic [n_ways-1:0] valid_vec;
  logic [n_ways-1:0] way_we;
  logic [paddr_bits-1:0] way_tag [n_ways];
  logic [tree_bits-1:0] wr_tree;
  logic [way_bits-1:0] match_way;
  logic [way_bits-1:0] inv_way;
  logic [way_bits-1:0] victim_way;
  logic [way_bits-1:0] fill_way;
  logic [way_bits-1:0] sel_way;
  logic is_fill;
  logic is_inval;
  logic is_init;
  tag_word_t wr_word;

  // Lowest set bit wins
  function automatic logic [way_bits-1:0] encode(input logic [n_ways-1:0] v);
    logic [way_bits-1:0] w;
    w = '0;
    for (int i = n_ways - 1; i >= 0; i--) begin
      if (v[i]) begin
        w = way_bits'(i);
      end
    end
    return w;
  endfunction

  always_ff @(negedge clk) begin
    if (rst) begin
      op_q <= OP_NONE;
    end else begin
      op_q <= write_op;
    end
  end

  always_ff @(negedge clk) begin
    write_paddr_q <= write_paddr;
  end

  assign is_fill = (op_q == OP_FILL);
  assign is_inval = (op_q == OP_INVAL);
  assign is_init = (op_q == OP_INIT);

  tag_way_if res [n_ways] ();

  for (genvar i = 0; i < n_ways; i++) begin : g_way
    tag_way u_way (
      .clk           (clk),
      .rst           (rst),
      .read_en       (read_en),
      .read_paddr    (read_paddr),
      .write_paddr   (write_paddr),
      .write_paddr_q (write_paddr_q),
      .wr_en         (way_we[i]),
      .wr_word       (wr_word),
      .res           (res[i])
    );

    assign hit_vec[i] = res[i].rd_hit;
    assign err_vec[i] = res[i].rd_err;
    assign match_vec[i] = res[i].wr_match;
    assign valid_vec[i] = res[i].wr_valid;
    assign way_tag[i] = res[i].wr_tag;
  end

  plru_tree u_tree (
    .clk      (clk),
    .rst      (rst),
    .rd_en    (read_en),
    .rd_set   (read_paddr[set_bits-1:0]),
    .hit      (read_hit),
    .hit_way  (read_way),
    .wr_set   (write_paddr[set_bits-1:0]),
    .fill     (is_fill),
    .fill_way (fill_way),
    .init     (is_init),
    .wr_tree  (wr_tree)
  );

  assign read_hit = |hit_vec;
  assign read_way = encode(hit_vec); // At most one way can hit
  assign read_err = |err_vec;

  // Follow the node bits from the root down to a leaf
  always_comb begin
    victim_way[2] = wr_tree[0];
    victim_way[1] = wr_tree[0] ? wr_tree[2] : wr_tree[1];
    victim_way[0] = wr_tree[3 + {victim_way[2], victim_way[1]}];
  end

  assign match_way = encode(match_vec);
  assign inv_way = encode(~valid_vec);

  always_comb begin
    if (|match_vec) begin
      fill_way = match_way;
    end else if (~&valid_vec) begin
      fill_way = inv_way;
    end else begin
      fill_way = victim_way;
    end
  end

  always_comb begin
    wr_word = '0; // Invalidate and init store a cleared word
    if (is_fill) begin
      wr_word.valid = 1'b1;
      wr_word.paddr = write_paddr_q;
      wr_word.parity = ^{1'b1, write_paddr_q};
    end
  end

  always_comb begin
    for (int i = 0; i < n_ways; i++) begin
      way_we[i] = is_init | (is_fill & (fill_way == way_bits'(i))) | (is_inval & match_vec[i]);
    end
  end

  // A full set without a match means the victim holds some other valid line
  assign expun_en = (is_fill & ~|match_vec & &valid_vec) | (is_inval & |match_vec);
  assign sel_way = is_fill ? fill_way : match_way;
  assign expun_addr = expun_en ? way_tag[sel_way] : '0;

endmodule

//--- tests/tag_model.svh
bit line_valid [n_sets][n_ways]; // One entry per set and way
logic [paddr_bits-1:0] line_tag [n_sets][n_ways];
logic [tree_bits-1:0] set_tree [n_sets];

// Returns the resident way of a line, or -1 when the line is absent
function automatic int find_way(input logic [paddr_bits-1:0] a);
  int s;
  s = int'(a[set_bits-1:0]);
  for (int w = 0; w < n_ways; w++) begin
    if (line_valid[s][w] && line_tag[s][w] == a) begin
      return w;
    end
  end
  return -1;
endfunction

// Node 0 picks the half, nodes 1 and 2 the quarter, nodes 3 to 6 the way
function automatic int tree_victim(input logic [tree_bits-1:0] t);
  int upper;
  int mid;
  upper = int'(t[0]);
  mid = (upper == 1) ? int'(t[2]) : int'(t[1]);
  return 4 * upper + 2 * mid + int'(t[3 + 2 * upper + mid]);
endfunction

// Every node on the path turns away from the way just used
function automatic logic [tree_bits-1:0] touch_tree(input logic [tree_bits-1:0] t, input int w);
  logic [tree_bits-1:0] n;
  int upper;
  int mid;
  n = t;
  upper = w / 4;
  mid = (w / 2) % 2;
  n[0] = (upper == 0);
  n[1 + upper] = (mid == 0);
  n[3 + 2 * upper + mid] = (w % 2 == 0);
  return n;
endfunction

function automatic int fill_target(input logic [paddr_bits-1:0] a);
  int s;
  int w;
  s = int'(a[set_bits-1:0]);
  w = find_way(a);
  if (w >= 0) begin
    return w;
  end
  for (int i = 0; i < n_ways; i++) begin
    if (!line_valid[s][i]) begin
      return i; // Lowest free way before any eviction
    end
  end
  return tree_victim(set_tree[s]);
endfunction

function automatic void init_set(input int s);
  for (int w = 0; w < n_ways; w++) begin
    line_valid[s][w] = 1'b0;
    line_tag[s][w] = '0;
  end
  set_tree[s] = '0;
endfunction

//--- tests/tag_array_tb.sv
`timescale 1ns/1ps

module tag_array_tb import tag_pkg::*; ();

  localparam int n_init = n_sets;
  localparam int n_rand = 3000;
  localparam int cycle_limit = 10 + n_init + n_rand + 100;

  logic clk;
  logic rst;
  logic read_en;
  logic [paddr_bits-1:0] read_paddr;
  logic read_hit;
  logic [way_bits-1:0] read_way;
  logic read_err;
  tag_op_e write_op;
  logic [paddr_bits-1:0] write_paddr;
  logic expun_en;
  logic [paddr_bits-1:0] expun_addr;

  // Request applied at the last rising edge and checked at the next one
  logic prev_ren = 1'b0;
  logic [paddr_bits-1:0] prev_raddr = '0;
  tag_op_e prev_op = OP_NONE;
  logic [paddr_bits-1:0] prev_waddr = '0;
  logic [63:0] rng = 64'd68;
  int cycles = 0;
  int n_hits = 0;
  int n_evicts = 0;

  `include "tag_model.svh"

  tag_array UUT (
    .clk         (clk),
    .rst         (rst),
    .read_en     (read_en),
    .read_paddr  (read_paddr),
    .read_hit    (read_hit),
    .read_way    (read_way),
    .read_err    (read_err),
    .write_op    (write_op),
    .write_paddr (write_paddr),
    .expun_en    (expun_en),
    .expun_addr  (expun_addr)
  );

  function automatic logic [63:0] next_rand(input logic [63:0] s);
    logic [63:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 7;
    x ^= x << 17;
    return x;
  endfunction

  // Sixteen lines per set over four sets keep the sets crowded
  function automatic logic [paddr_bits-1:0] make_paddr(input logic [63:0] r);
    return {26'h2a5f3c1, r[5:2], 5'd0, r[1:0]};
  endfunction

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic mismatch(input string name, input logic [63:0] got, input logic [63:0] exp);
    stop_run($sformatf("ERR time %0t: %s is %h, expected %h", $time, name, got, exp));
  endtask

  task automatic drive(input logic ren, input logic [paddr_bits-1:0] ra, input tag_op_e op,
                       input logic [paddr_bits-1:0] wa);
    read_en <= ren;
    read_paddr <= ra;
    write_op <= op;
    write_paddr <= wa;
    prev_ren = ren;
    prev_raddr = ra;
    prev_op = op;
    prev_waddr = wa;
  endtask

  // Predicts the outputs for the previous requests and then updates the model
  task automatic check_cycle();
    int hw;
    int mw;
    int fw;
    int rs;
    int ws;
    logic exp_hit;
    logic exp_en;
    logic [paddr_bits-1:0] exp_addr;
    rs = int'(prev_raddr[set_bits-1:0]);
    ws = int'(prev_waddr[set_bits-1:0]);
    hw = find_way(prev_raddr);
    mw = find_way(prev_waddr);
    fw = fill_target(prev_waddr);
    exp_hit = prev_ren && hw >= 0;
    exp_en = 1'b0;
    exp_addr = '0;
    if (prev_op == OP_FILL && mw < 0 && line_valid[ws][fw]) begin
      exp_en = 1'b1;
      exp_addr = line_tag[ws][fw];
    end else if (prev_op == OP_INVAL && mw >= 0) begin
      exp_en = 1'b1;
      exp_addr = line_tag[ws][mw];
    end
    assert (read_hit === exp_hit) else mismatch("read_hit", 64'(read_hit), 64'(exp_hit));
    if (exp_hit) begin
      assert (read_way === way_bits'(hw)) else mismatch("read_way", 64'(read_way), 64'(hw));
    end
    assert (read_err === 1'b0) else mismatch("read_err", 64'(read_err), 64'd0);
    assert (expun_en === exp_en) else mismatch("expun_en", 64'(expun_en), 64'(exp_en));
    assert (expun_addr === exp_addr)
      else mismatch("expun_addr", 64'(expun_addr), 64'(exp_addr));
    if (prev_op == OP_INIT) begin
      init_set(ws);
    end else if (prev_op == OP_FILL) begin
      line_valid[ws][fw] = 1'b1;
      line_tag[ws][fw] = prev_waddr;
      set_tree[ws] = touch_tree(set_tree[ws], fw);
    end else if (exp_hit) begin
      set_tree[rs] = touch_tree(set_tree[rs], hw); // Tree port is free this cycle
    end
    if (prev_op == OP_INVAL && mw >= 0) begin
      line_valid[ws][mw] = 1'b0;
      line_tag[ws][mw] = '0;
    end
    n_hits += int'(exp_hit);
    n_evicts += int'(exp_en && prev_op == OP_FILL);
  endtask

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      stop_run("Run hit the cycle limit before the test sequence finished");
    end
  end

  initial begin
    logic [4:0] sel;
    tag_op_e op;
    rst = 1'b1;
    read_en = 1'b0;
    read_paddr = '0;
    write_op = OP_NONE;
    write_paddr = '0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    for (int cyc = 0; cyc <= n_init + n_rand; cyc++) begin
      @(posedge clk);
      check_cycle();
      rng = next_rand(rng);
      sel = rng[12:8];
      op = OP_NONE;
      if (sel == 5'd0) begin
        op = OP_INIT;
      end else if (sel < 5'd5) begin
        op = OP_INVAL;
      end else if (sel < 5'd20) begin
        op = OP_FILL;
      end
      if (cyc < n_init) begin
        // Clear each set once and read back the set cleared one cycle earlier
        drive(cyc > 0, {rng[29:0], set_bits'(cyc - 1)}, OP_INIT, paddr_bits'(cyc));
      end else if (cyc < n_init + n_rand) begin
        drive(rng[15:13] != 3'd0, make_paddr(rng), op, make_paddr(rng >> 24));
      end else begin
        drive(1'b0, '0, OP_NONE, '0);
      end
    end
    if (n_hits == 0 || n_evicts == 0) begin
      stop_run("Random phase produced no read hits or no evictions");
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

//--- src.f
+incdir+tests
logic/tag_pkg.sv
logic/tag_way_if.sv
logic/tag_ram.sv
logic/plru_tree.sv
logic/tag_way.sv
logic/tag_array.sv
tests/tag_array_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing
TOP = tag_array_tb
FILELIST = src.f
BUILD = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	out=$$(./$(BUILD)/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "^TESTS PASSED$$"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD)
